//--- blimp_pkg.sv
// ------------------------------------------------
// Shared definitions for the blimp core
// Opcodes, reset vector, Wishbone and trace structs
// Instruction word views and decoded fields
// ------------------------------------------------

package blimp_pkg;

  // ------------------------------------------------
  // Widths and constants
  // ------------------------------------------------

  // Data and address width
  localparam int xlen = 32;

  // First fetch address
  localparam logic [xlen-1:0] reset_pc = 32'h0;

  // Major opcodes, register and immediate arithmetic
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;

  // M extension funct7
  localparam logic [6:0] funct7_mul = 7'b0000001;

  // Operations the core understands
  typedef enum logic [1:0] {
    alu_add,
    alu_addi,
    alu_mul,
    alu_none
  } alu_op_e;

  // ------------------------------------------------
  // Instruction word
  // ------------------------------------------------

  // Register-register layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Same 32 bits, two decodings
  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
  } inst_u;

  // Decoder output
  typedef struct packed {
    alu_op_e         op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
  } decoded_t;

  // ------------------------------------------------
  // Bus and trace
  // ------------------------------------------------

  // Wishbone classic request, read only
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [xlen-1:0] adr;
  } wb_req_t;

  // Wishbone classic response
  typedef struct packed {
    logic            ack;
    logic [xlen-1:0] dat;
  } wb_rsp_t;

  // One entry per retired instruction
  typedef struct packed {
    logic            val;
    logic [xlen-1:0] pc;
    logic [4:0]      waddr;
    logic [xlen-1:0] wdata;
    logic            wen;
  } inst_trace_t;

endpackage

//--- blimp_regfile.sv
// ------------------------------------------------
// 32 x 32 register file, two reads, one write
// x0 hardwired to zero
// ------------------------------------------------

`timescale 1ns/10ps

module blimp_regfile (
  input  logic                       clk,
  input  logic [4:0]                 rs1,
  input  logic [4:0]                 rs2,
  output logic [blimp_pkg::xlen-1:0] rd1,
  output logic [blimp_pkg::xlen-1:0] rd2,
  input  logic                       wen,
  input  logic [4:0]                 waddr,
  input  logic [blimp_pkg::xlen-1:0] wdata
);

  // Storage, entry 0 never written
  logic [blimp_pkg::xlen-1:0] regs [32];

  // Write on the clock edge
  // x0 writes dropped here
  always_ff @(posedge clk) begin
    if (wen && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads
  always_comb begin
    rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];
  end

endmodule

//--- blimp_decode.sv
// ------------------------------------------------
// Instruction decoder
// Operation, register indices, sign-extended imm
// ------------------------------------------------

`timescale 1ns/10ps

module blimp_decode (
  input  blimp_pkg::inst_u    inst,
  output blimp_pkg::decoded_t dec
);

  // Fields common to both views
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst.r_type.opcode;
  assign funct3 = inst.r_type.funct3;
  assign funct7 = inst.r_type.funct7;

  always_comb begin
    // Register indices straight from the R-type view
    dec.rs1 = inst.r_type.rs1;
    dec.rs2 = inst.r_type.rs2;
    dec.rd  = inst.r_type.rd;

    // I-type immediate, sign-extended from bit 11
    dec.imm = {{(blimp_pkg::xlen-12){inst.i_type.imm[11]}}, inst.i_type.imm};

    // Operation select
    // ADD, MUL and ADDI all use funct3 zero
    dec.op = blimp_pkg::alu_none;
    if ((opcode == blimp_pkg::opcode_op) && (funct3 == 3'b000)) begin
      if (funct7 == 7'b0000000) begin
        dec.op = blimp_pkg::alu_add;
      end else if (funct7 == blimp_pkg::funct7_mul) begin
        dec.op = blimp_pkg::alu_mul;
      end
    end else if ((opcode == blimp_pkg::opcode_op_imm) && (funct3 == 3'b000)) begin
      dec.op = blimp_pkg::alu_addi;
    end

    // Unknown instructions retire without a write
    if (dec.op == blimp_pkg::alu_none) begin
      dec.rd = 5'd0;
    end
  end

endmodule

//--- blimp_mul_steps.sv
// ------------------------------------------------
// Multiply step counter
// 32 iterations, flags the final one
// ------------------------------------------------

`timescale 1ns/10ps

module blimp_mul_steps (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic busy,
  output logic last_step
);

  // Steps remaining after the current one
  logic [4:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= 5'd0;
    end else if (start) begin
      // 32 steps, 31 down to 0
      busy  <= 1'b1;
      count <= 5'd31;
    end else if (busy) begin
      if (count == 5'd0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 5'd1;
      end
    end
  end

  // High during the final step only
  assign last_step = busy && (count == 5'd0);

endmodule

//--- blimp_mul_unit.sv
// ------------------------------------------------
// Iterative shift-add multiplier datapath
// One multiplier bit per step, low 32 bits kept
// ------------------------------------------------

`timescale 1ns/10ps

module blimp_mul_unit (
  input  logic                       clk,
  input  logic                       start,
  input  logic                       step,
  input  logic [blimp_pkg::xlen-1:0] a,
  input  logic [blimp_pkg::xlen-1:0] b,
  output logic [blimp_pkg::xlen-1:0] product
);

  // Multiplicand, shifted left each step
  logic [blimp_pkg::xlen-1:0] mcand;
  // Multiplier, shifted right each step
  logic [blimp_pkg::xlen-1:0] mplier;
  // Running sum of partial products
  logic [blimp_pkg::xlen-1:0] acc;

  // Partial product for this step
  logic [blimp_pkg::xlen-1:0] partial;

  assign partial = mplier[0] ? mcand : '0;

  always_ff @(posedge clk) begin
    if (start) begin
      // Load operands, clear the sum
      mcand  <= a;
      mplier <= b;
      acc    <= '0;
    end else if (step) begin
      // Upper bits of the product fall off the top
      acc    <= acc + partial;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // Valid once the last step has been taken
  assign product = acc;

endmodule

//--- blimp_ctrl.sv
// ------------------------------------------------
// Core controller FSM: FETCH, EXEC, MUL, WB
// Owns pc, instruction register, Wishbone fetch
// Adds, writeback and trace output
// ------------------------------------------------

`timescale 1ns/10ps

module blimp_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  output blimp_pkg::wb_req_t          wb_req,
  input  blimp_pkg::wb_rsp_t          wb_rsp,
  output blimp_pkg::inst_u            inst,
  input  blimp_pkg::decoded_t         dec,
  input  logic [blimp_pkg::xlen-1:0]  rd1,
  input  logic [blimp_pkg::xlen-1:0]  rd2,
  output logic                        rf_wen,
  output logic [4:0]                  rf_waddr,
  output logic [blimp_pkg::xlen-1:0]  rf_wdata,
  output logic                        mul_start,
  input  logic                        mul_busy,
  input  logic                        mul_last,
  input  logic [blimp_pkg::xlen-1:0]  product,
  output blimp_pkg::inst_trace_t      trace
);

  typedef enum logic [1:0] {
    st_fetch,
    st_exec,
    st_mul,
    st_wb
  } state_e;

  state_e state;
  state_e state_next;

  logic [blimp_pkg::xlen-1:0] pc;
  // Sum from EXEC
  logic [blimp_pkg::xlen-1:0] result;
  // Registered cyc and stb, low during reset
  logic fetch_active;
  logic is_mul;

  assign is_mul = (dec.op == blimp_pkg::alu_mul);

  // ------------------------------------------------
  // Next state
  // ------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_fetch: if (fetch_active && wb_rsp.ack) state_next = st_exec;
      st_exec:  state_next = is_mul ? st_mul : st_wb;
      // Leave on the final step, or if the counter went idle
      st_mul:   if (mul_last || !mul_busy) state_next = st_wb;
      st_wb:    state_next = st_fetch;
      default:  state_next = st_fetch;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= st_fetch;
      fetch_active <= 1'b0;
      pc           <= blimp_pkg::reset_pc;
    end else begin
      state        <= state_next;
      // Request drops the cycle after ack
      fetch_active <= (state_next == st_fetch);
      if (state == st_wb) begin
        pc <= pc + 32'd4;
      end
    end
  end

  // Instruction word and sum
  always_ff @(posedge clk) begin
    if ((state == st_fetch) && fetch_active && wb_rsp.ack) begin
      inst <= wb_rsp.dat;
    end
    if (state == st_exec) begin
      result <= (dec.op == blimp_pkg::alu_addi) ? rd1 + dec.imm : rd1 + rd2;
    end
  end

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------

  always_comb begin
    wb_req.cyc = fetch_active;
    wb_req.stb = fetch_active;
    wb_req.adr = pc;
  end

  // Multiplier kicked off from EXEC
  assign mul_start = (state == st_exec) && is_mul;

  // Commit in WB, x0 never written
  assign rf_wen   = (state == st_wb) && (dec.rd != 5'd0);
  assign rf_waddr = dec.rd;
  assign rf_wdata = is_mul ? product : result;

  always_comb begin
    trace.val   = (state == st_wb);
    trace.pc    = pc;
    trace.waddr = dec.rd;
    trace.wdata = rf_wdata;
    trace.wen   = rf_wen;
  end

endmodule

//--- blimp_core.sv
// ------------------------------------------------
// blimp core top level
// Controller, decoder, register file, multiplier
// ------------------------------------------------

`timescale 1ns/10ps

module blimp_core (
  input  logic                   clk,
  input  logic                   reset,
  output blimp_pkg::wb_req_t     wb_req,
  output logic                   wb_we,
  input  blimp_pkg::wb_rsp_t     wb_rsp,
  output blimp_pkg::inst_trace_t trace
);

  blimp_pkg::inst_u    inst;
  blimp_pkg::decoded_t dec;

  // Register file ports
  logic [blimp_pkg::xlen-1:0] rd1;
  logic [blimp_pkg::xlen-1:0] rd2;
  logic                       rf_wen;
  logic [4:0]                 rf_waddr;
  logic [blimp_pkg::xlen-1:0] rf_wdata;

  // Multiplier handshake
  logic                       mul_start;
  logic                       mul_busy;
  logic                       mul_last;
  logic [blimp_pkg::xlen-1:0] product;

  // Fetch only, never a write
  assign wb_we = 1'b0;

  // ------------------------------------------------
  // Control and decode
  // ------------------------------------------------

  blimp_ctrl ctrl (
    .clk       (clk),
    .reset     (reset),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .inst      (inst),
    .dec       (dec),
    .rd1       (rd1),
    .rd2       (rd2),
    .rf_wen    (rf_wen),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata),
    .mul_start (mul_start),
    .mul_busy  (mul_busy),
    .mul_last  (mul_last),
    .product   (product),
    .trace     (trace)
  );

  blimp_decode decode (
    .inst (inst),
    .dec  (dec)
  );

  blimp_regfile regfile (
    .clk   (clk),
    .rs1   (dec.rs1),
    .rs2   (dec.rs2),
    .rd1   (rd1),
    .rd2   (rd2),
    .wen   (rf_wen),
    .waddr (rf_waddr),
    .wdata (rf_wdata)
  );

  // ------------------------------------------------
  // Multiplier, counter busy steps the datapath
  // ------------------------------------------------

  blimp_mul_steps mul_steps (
    .clk       (clk),
    .reset     (reset),
    .start     (mul_start),
    .busy      (mul_busy),
    .last_step (mul_last)
  );

  blimp_mul_unit mul_unit (
    .clk     (clk),
    .start   (mul_start),
    .step    (mul_busy),
    .a       (rd1),
    .b       (rd2),
    .product (product)
  );

endmodule

//--- tb_blimp_mem.sv
// ------------------------------------------------
// Wishbone classic instruction memory model
// Read only, random 0 to 3 wait cycles per request
// ------------------------------------------------

`timescale 1ns/10ps

module tb_blimp_mem (
  input  logic               clk,
  input  logic               reset,
  input  blimp_pkg::wb_req_t req,
  output blimp_pkg::wb_rsp_t rsp
);

  // 512 words, filled and loaded by the testbench
  logic [31:0] words [512];

  // Response registers, change on the falling edge
  logic        ack_q = 1'b0;
  logic [31:0] dat_q = 32'h0;

  // Request seen, waiting out its delay
  logic        armed = 1'b0;
  logic [1:0]  wait_left = 2'd0;

  // Delay source
  logic [31:0] rng = 32'h7bff;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  assign rsp = {ack_q, dat_q};

  always @(negedge clk) begin
    // Ack is a single-cycle pulse
    ack_q <= 1'b0;
    if (reset) begin
      armed <= 1'b0;
    end else if (req.cyc && req.stb && !ack_q) begin
      if (!armed) begin
        // New request, draw its wait count
        rng = xorshift32(rng);
        if (rng[1:0] == 2'd0) begin
          ack_q <= 1'b1;
          dat_q <= words[req.adr[10:2]];
        end else begin
          armed     <= 1'b1;
          wait_left <= rng[1:0];
        end
      end else if (wait_left == 2'd1) begin
        // Last wait cycle done
        ack_q <= 1'b1;
        dat_q <= words[req.adr[10:2]];
        armed <= 1'b0;
      end else begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

endmodule

//--- tb_blimp_core.sv
// ------------------------------------------------
// Testbench for the blimp core
// Clock, reset, program loading, reference model
// Bus, trace and timing checks
// ------------------------------------------------

`timescale 1ns/10ps

module tb_blimp_core;

  logic                   clk;
  logic                   reset = 1'b1;
  blimp_pkg::wb_req_t     wb_req;
  logic                   wb_we;
  blimp_pkg::wb_rsp_t     wb_rsp;
  blimp_pkg::inst_trace_t trace;

  // Expected retirements in program order
  blimp_pkg::inst_trace_t exp_q [$];
  int                     lat_q [$];

  // Reference architectural state
  logic [31:0] ref_regs [32];
  logic [31:0] prog_pc;
  logic [31:0] rng = 32'h7bff;

  int errors = 0;
  int err_base = 0;
  int failed_tests = 0;
  int fetches = 0;
  int traces = 0;

  // Monitor state sampled on the rising edge
  int          cycle = 0;
  int          ack_cycle = 0;
  int          since_rst = 0;
  logic        reset_q = 1'b0;
  logic        stb_q = 1'b0;
  logic        ack_q = 1'b0;
  logic        val_q = 1'b0;
  logic [31:0] adr_q = 32'h0;

  blimp_core uut (
    .clk    (clk),
    .reset  (reset),
    .wb_req (wb_req),
    .wb_we  (wb_we),
    .wb_rsp (wb_rsp),
    .trace  (trace)
  );

  tb_blimp_mem imem (
    .clk   (clk),
    .reset (reset),
    .req   (wb_req),
    .rsp   (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------
  // Reporting and encoding
  // ------------------------------------------------

  task automatic report_mismatch(input string msg);
    $display("ERR %0t %s", $time, msg);
    errors++;
  endtask

  task automatic report_fault(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // RV32 R-type and I-type with funct3 zero
  function automatic logic [31:0] encode_r(input logic [6:0] funct7,
                                           input logic [4:0] rs2, rs1, rd);
    return {funct7, rs2, rs1, 3'b000, rd, blimp_pkg::opcode_op};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm,
                                           input logic [4:0] rs1, rd);
    return {imm, rs1, 3'b000, rd, blimp_pkg::opcode_op_imm};
  endfunction

  // ------------------------------------------------
  // Program building with the reference model
  // ------------------------------------------------

  task automatic place(input logic [31:0] word, input logic [4:0] rd,
                       input logic [31:0] wdata, input int lat);
    blimp_pkg::inst_trace_t e;
    imem.words[prog_pc[10:2]] = word;
    e.val   = 1'b1;
    e.pc    = prog_pc;
    e.waddr = rd;
    e.wdata = wdata;
    e.wen   = (rd != 5'd0);
    exp_q.push_back(e);
    lat_q.push_back(lat);
    // x0 stays zero
    if (rd != 5'd0) ref_regs[rd] = wdata;
    prog_pc = prog_pc + 32'd4;
  endtask

  task automatic emit_add(input logic [4:0] rd, rs1, rs2);
    place(encode_r(7'b0000000, rs2, rs1, rd), rd, ref_regs[rs1] + ref_regs[rs2], 2);
  endtask

  task automatic emit_addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    place(encode_i(imm, rs1, rd), rd, ref_regs[rs1] + {{20{imm[11]}}, imm}, 2);
  endtask

  task automatic emit_mul(input logic [4:0] rd, rs1, rs2);
    place(encode_r(blimp_pkg::funct7_mul, rs2, rs1, rd), rd,
          ref_regs[rs1] * ref_regs[rs2], 34);
  endtask

  // Unsupported word retires with no write
  task automatic emit_other(input logic [31:0] word);
    place(word, 5'd0, 32'h0, 2);
  endtask

  // Full 32-bit constant in 10 + 11 + 11 bit chunks
  // ADD doubles between chunks
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    emit_addi(rd, 5'd0, {2'b00, v[31:22]});
    repeat (11) emit_add(rd, rd, rd);
    emit_addi(rd, rd, {1'b0, v[21:11]});
    repeat (11) emit_add(rd, rd, rd);
    emit_addi(rd, rd, {1'b0, v[10:0]});
  endtask

  // ------------------------------------------------
  // Test sequencing
  // ------------------------------------------------

  task automatic begin_test();
    int i;
    @(negedge clk);
    reset <= 1'b1;
    @(negedge clk);
    // Unused words decode as unsupported and carry their index
    for (i = 0; i < 512; i++) imem.words[i] = {i[24:0], 7'h7f};
    for (i = 0; i < 32; i++) ref_regs[i] = 32'h0;
    exp_q.delete();
    lat_q.delete();
    prog_pc  = blimp_pkg::reset_pc;
    fetches  = 0;
    traces   = 0;
    err_base = errors;
  endtask

  task automatic run_program(input int num);
    int   idle;
    int   left;
    logic stalled;
    stalled = 1'b0;
    // Ten reset cycles in total
    repeat (9) @(negedge clk);
    reset <= 1'b0;
    while (exp_q.size() > 0 && !stalled) begin
      left = exp_q.size();
      idle = 0;
      while (exp_q.size() == left && idle < 200) begin
        @(negedge clk);
        idle++;
      end
      if (exp_q.size() == left) begin
        report_fault($sformatf("test %0d stalled, no retirement within 200 cycles", num));
        stalled = 1'b1;
      end
    end
  endtask

  task automatic finish_test(input int num, input string name);
    assert (fetches == traces)
      else report_mismatch($sformatf("%0d fetches for %0d retirements", fetches, traces));
    if (errors == err_base) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - err_base);
      failed_tests++;
    end
  endtask

  // ------------------------------------------------
  // Monitors sampled on the rising edge
  // ------------------------------------------------

  task automatic check_retire();
    blimp_pkg::inst_trace_t e;
    int lat;
    traces++;
    assert (!val_q) else report_fault("trace valid held for more than one cycle");
    if (exp_q.size() == 0) begin
      report_fault($sformatf("retirement at pc %h with nothing expected", trace.pc));
    end else begin
      e   = exp_q.pop_front();
      lat = lat_q.pop_front();
      assert (trace.pc == e.pc)
        else report_mismatch($sformatf("pc %h, expected %h", trace.pc, e.pc));
      assert (trace.waddr == e.waddr && trace.wen == e.wen)
        else report_mismatch($sformatf("pc %h waddr %0d wen %b, expected %0d %b",
                                       e.pc, trace.waddr, trace.wen, e.waddr, e.wen));
      assert (!e.wen || trace.wdata == e.wdata)
        else report_mismatch($sformatf("pc %h wdata %h, expected %h",
                                       e.pc, trace.wdata, e.wdata));
      assert (cycle - ack_cycle == lat)
        else report_mismatch($sformatf("pc %h ack to retire %0d cycles, expected %0d",
                                       e.pc, cycle - ack_cycle, lat));
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (reset) begin
      since_rst = 0;
      // One cycle for the reset to take hold
      if (reset_q) begin
        assert (!wb_req.cyc && !wb_req.stb && !trace.val)
          else report_fault("bus request or trace active during reset");
      end
    end else begin
      since_rst = since_rst + 1;
      if (since_rst == 2) begin
        assert (wb_req.stb && wb_req.adr == blimp_pkg::reset_pc)
          else report_mismatch($sformatf("first fetch stb %b adr %h", wb_req.stb, wb_req.adr));
      end
      assert (!wb_we) else report_fault("write enable raised on the fetch port");
      assert (!wb_req.stb || wb_req.cyc) else report_fault("stb high without cyc");
      // Held until the ack
      if (stb_q && !ack_q) begin
        assert (wb_req.stb && wb_req.adr == adr_q)
          else report_fault("stb or adr changed before the ack");
      end
      if (ack_q) begin
        assert (!wb_req.cyc) else report_fault("cyc still high the cycle after ack");
      end
      if (wb_rsp.ack && wb_req.stb) begin
        fetches++;
        ack_cycle = cycle;
      end
      if (trace.val) check_retire();
    end
    reset_q = reset;
    stb_q   = wb_req.stb;
    ack_q   = wb_rsp.ack;
    adr_q   = wb_req.adr;
    val_q   = trace.val;
  end

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------

  initial begin
    int k;
    logic [4:0] rd_sel;

    begin_test();
    emit_addi(5'd1, 5'd0, 12'd5);
    emit_addi(5'd2, 5'd1, -12'sd3);
    run_program(1);
    finish_test(1, "reset and first fetch");

    begin_test();
    emit_addi(5'd1, 5'd0, 12'd1000);
    emit_addi(5'd2, 5'd0, -12'sd2000);
    emit_add(5'd3, 5'd1, 5'd2);
    for (k = 0; k < 8; k++) begin
      emit_add(5'd3, 5'd3, 5'd1);
      emit_addi(5'd4, 5'd3, 12'h7ff);
      emit_add(5'd5, 5'd4, 5'd4);
    end
    // Wrap past the top of the range
    load_const(5'd6, 32'h7fff_ffff);
    emit_add(5'd7, 5'd6, 5'd6);
    emit_add(5'd7, 5'd7, 5'd6);
    run_program(2);
    finish_test(2, "addi and add chains");

    begin_test();
    for (k = 0; k < 3; k++) begin
      rng = xorshift32(rng);
      load_const(5'd10, rng);
      rng = xorshift32(rng);
      load_const(5'd11, rng);
      emit_mul(5'd12, 5'd10, 5'd11);
    end
    // Zero and minus one operands
    emit_mul(5'd13, 5'd10, 5'd0);
    emit_addi(5'd14, 5'd0, -12'sd1);
    emit_mul(5'd15, 5'd10, 5'd14);
    emit_mul(5'd16, 5'd14, 5'd14);
    emit_addi(5'd17, 5'd0, 12'd0);
    emit_mul(5'd18, 5'd17, 5'd11);
    run_program(3);
    finish_test(3, "mul with random operands");

    begin_test();
    emit_addi(5'd1, 5'd0, 12'd77);
    emit_addi(5'd0, 5'd1, 12'd55);
    emit_add(5'd0, 5'd1, 5'd1);
    emit_mul(5'd0, 5'd1, 5'd1);
    // ecall, beq, slli and sub
    emit_other(32'h0000_0073);
    emit_other(32'h00a0_8063);
    emit_other(32'h0010_9093);
    emit_other(encode_r(7'b0100000, 5'd1, 5'd1, 5'd2));
    emit_add(5'd2, 5'd0, 5'd0);
    emit_addi(5'd3, 5'd0, 12'd0);
    emit_add(5'd4, 5'd0, 5'd1);
    run_program(4);
    finish_test(4, "x0 writes and unsupported opcodes");

    begin_test();
    for (k = 1; k < 8; k++) begin
      rng = xorshift32(rng);
      emit_addi(k[4:0], 5'd0, rng[11:0]);
    end
    for (k = 0; k < 40; k++) begin
      rng = xorshift32(rng);
      rd_sel = {2'b00, rng[10:8]};
      if (rd_sel == 5'd0) rd_sel = 5'd7;
      if (rng[0]) begin
        emit_add(rd_sel, {2'b00, rng[14:12]}, {2'b00, rng[18:16]});
      end else begin
        emit_addi(rd_sel, {2'b00, rng[14:12]}, rng[31:20]);
      end
    end
    run_program(5);
    finish_test(5, "wishbone rules under random delay");

    begin_test();
    emit_addi(5'd1, 5'd0, 12'd300);
    emit_addi(5'd2, 5'd0, -12'sd7);
    emit_mul(5'd3, 5'd1, 5'd2);
    emit_other(32'h0000_0073);
    emit_add(5'd4, 5'd3, 5'd1);
    emit_mul(5'd5, 5'd4, 5'd4);
    emit_other(32'h0000_0000);
    emit_addi(5'd6, 5'd5, 12'd1);
    run_program(6);
    finish_test(6, "ack to retire timing");

    $display("summary: 6 tests run, %0d with errors, %0d errors in total",
             failed_tests, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- list.f
blimp_pkg.sv
blimp_regfile.sv
blimp_decode.sv
blimp_mul_steps.sv
blimp_mul_unit.sv
blimp_ctrl.sv
blimp_core.sv
tb_blimp_mem.sv
tb_blimp_core.sv
